// File: Bender.yml
package:
  name: rdma_reg

sources:
  - files:
      - design/rdma_reg_pkg.sv
      - design/csb_req_decode.sv
      - design/reg_access_route.sv
      - design/ptr_status_group.sv
      - design/layer_cfg_group.sv
      - design/pingpong_ctrl.sv
      - design/csb_resp_pack.sv
      - design/rdma_reg_top.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/rdma_reg_tb.sv

// File: design/csb_req_decode.sv
/* csb request stage: registers the strobe and packet,
   unpacks them into register access strobes */
module csb_req_decode import rdma_reg_pkg::*; (
  input  logic        autosa_core_clk,
  input  logic        autosa_core_rstn,
  input  logic        csb2cdp_rdma_req_pvld,
  input  csb_req_pd_t csb2cdp_rdma_req_pd,
  output logic        csb2cdp_rdma_req_prdy,
  output logic        reg_wr_en,
  output logic        reg_rd_en,
  output logic        reg_nposted,
  output reg_offset_t reg_offset,
  output reg_data_t   reg_wr_data
);

  logic        req_pvld_q;
  csb_req_pd_t req_pd_q;
  csb_addr_t   req_addr;
  logic        req_write;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      req_pvld_q <= 1'b0;
    end else begin
      req_pvld_q <= csb2cdp_rdma_req_pvld;  // one cycle strobe
    end
  end

  // packet captured only with its strobe
  always_ff @(posedge autosa_core_clk) begin
    if (csb2cdp_rdma_req_pvld) begin
      req_pd_q <= csb2cdp_rdma_req_pd;
    end
  end

  // unpack
  assign req_addr    = req_pd_q[CSB_ADDR_W-1:0];
  assign req_write   = req_pd_q[REQ_WRITE_BIT];
  assign reg_nposted = req_pd_q[REQ_NPOSTED_BIT];
  assign reg_wr_data = req_pd_q[REQ_WDAT_LSB +: REG_DATA_W];

  // word address to byte offset, upper bits outside 4 KB dropped
  assign reg_offset = {req_addr[REG_OFFSET_W-3:0], 2'b00};

  assign reg_wr_en = req_pvld_q & req_write;
  assign reg_rd_en = req_pvld_q & ~req_write;

  assign csb2cdp_rdma_req_prdy = 1'b1;  // never back-pressures

  a_req_pvld_known: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !$isunknown(csb2cdp_rdma_req_pvld))
    else $error("csb request valid is X");

endmodule

// File: design/csb_resp_pack.sv
/* csb response stage: read and non-posted write response packets */
module csb_resp_pack import rdma_reg_pkg::*; (
  input  logic         autosa_core_clk,
  input  logic         autosa_core_rstn,
  input  logic         reg_rd_en,
  input  logic         reg_wr_en,
  input  logic         reg_nposted,
  input  reg_data_t    reg_rd_data,
  output logic         cdp_rdma2csb_resp_valid,
  output csb_resp_pd_t cdp_rdma2csb_resp_pd
);

  logic wr_resp;

  assign wr_resp = reg_wr_en & reg_nposted;  // posted writes stay silent

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cdp_rdma2csb_resp_valid <= 1'b0;
    end else begin
      cdp_rdma2csb_resp_valid <= reg_rd_en | wr_resp;
    end
  end

  // {type, error, data}, error never raised
  always_ff @(posedge autosa_core_clk) begin
    if (reg_rd_en) begin
      cdp_rdma2csb_resp_pd <= {RESP_TYPE_RD, 1'b0, reg_rd_data};
    end else if (wr_resp) begin
      cdp_rdma2csb_resp_pd <= {RESP_TYPE_WR, 1'b0, {REG_DATA_W{1'b0}}};
    end
  end

endmodule

// File: design/layer_cfg_group.sv
/* one ping-pong copy of the layer configuration:
   cube dims, source base and line stride, op_en trigger */
module layer_cfg_group import rdma_reg_pkg::*; (
  input  logic        autosa_core_clk,
  input  logic        autosa_core_rstn,
  input  logic        wr_en,
  input  reg_offset_t reg_offset,
  input  reg_data_t   reg_wr_data,
  input  logic        op_en,
  output logic        op_en_set,
  output cube_dim_t   width,
  output cube_dim_t   height,
  output cube_dim_t   channel,
  output reg_data_t   src_base_addr_low,
  output reg_data_t   src_line_stride,
  output reg_data_t   rd_data
);

  //////////////////////////////////////////////////
  // config fields
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      width             <= '0;
      height            <= '0;
      channel           <= '0;
      src_base_addr_low <= '0;
      src_line_stride   <= '0;
    end else if (wr_en) begin
      case (reg_offset)
        WIDTH_OFFS:        width             <= reg_wr_data[CUBE_DIM_W-1:0];  // truncated
        HEIGHT_OFFS:       height            <= reg_wr_data[CUBE_DIM_W-1:0];
        CHANNEL_OFFS:      channel           <= reg_wr_data[CUBE_DIM_W-1:0];
        SRC_BASE_LOW_OFFS: src_base_addr_low <= reg_wr_data;
        LINE_STRIDE_OFFS:  src_line_stride   <= reg_wr_data;
        default: ;
      endcase
    end
  end

  // op_en itself lives in the ping-pong control
  assign op_en_set = wr_en & (reg_offset == OP_ENABLE_OFFS) & reg_wr_data[0];

  //////////////////////////////////////////////////
  // readback
  always_comb begin
    rd_data = '0;
    case (reg_offset)
      OP_ENABLE_OFFS:    rd_data[0] = op_en;
      WIDTH_OFFS:        rd_data[CUBE_DIM_W-1:0] = width;
      HEIGHT_OFFS:       rd_data[CUBE_DIM_W-1:0] = height;
      CHANNEL_OFFS:      rd_data[CUBE_DIM_W-1:0] = channel;
      SRC_BASE_LOW_OFFS: rd_data = src_base_addr_low;
      LINE_STRIDE_OFFS:  rd_data = src_line_stride;
      default: ;  // unmapped reads 0
    endcase
  end

endmodule

// File: design/pingpong_ctrl.sv
/* ping-pong control: consumer pointer, per-group op_en bits,
   op_en delay pipe to the datapath, consumer field mux */
module pingpong_ctrl import rdma_reg_pkg::*; (
  input  logic      autosa_core_clk,
  input  logic      autosa_core_rstn,
  input  logic      dp2reg_done,
  input  logic      d0_op_en_set,
  input  logic      d1_op_en_set,
  input  cube_dim_t d0_width,
  input  cube_dim_t d0_height,
  input  cube_dim_t d0_channel,
  input  reg_data_t d0_src_base_addr_low,
  input  reg_data_t d0_src_line_stride,
  input  cube_dim_t d1_width,
  input  cube_dim_t d1_height,
  input  cube_dim_t d1_channel,
  input  reg_data_t d1_src_base_addr_low,
  input  reg_data_t d1_src_line_stride,
  output logic      consumer,
  output logic      d0_op_en,
  output logic      d1_op_en,
  output logic      reg2dp_op_en,
  output cube_dim_t reg2dp_width,
  output cube_dim_t reg2dp_height,
  output cube_dim_t reg2dp_channel,
  output reg_data_t reg2dp_src_base_addr_low,
  output reg_data_t reg2dp_src_line_stride
);

  logic                   op_en_cur;   // op_en of the consumed group
  logic [OP_EN_DELAY-1:0] op_en_pipe;

  //////////////////////////////////////////////////
  // consumer and op_en bits
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      consumer <= 1'b0;
      d0_op_en <= 1'b0;
      d1_op_en <= 1'b0;
    end else begin
      if (dp2reg_done) begin
        consumer <= ~consumer;  // move on to the other copy
      end
      if (d0_op_en_set) begin
        d0_op_en <= 1'b1;
      end else if (dp2reg_done && !consumer) begin
        d0_op_en <= 1'b0;  // layer on group 0 finished
      end
      if (d1_op_en_set) begin
        d1_op_en <= 1'b1;
      end else if (dp2reg_done && consumer) begin
        d1_op_en <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // op_en delay to datapath
  assign op_en_cur = consumer ? d1_op_en : d0_op_en;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      op_en_pipe <= '0;
    end else if (dp2reg_done) begin
      op_en_pipe <= '0;  // drop right away, refill from new consumer
    end else begin
      op_en_pipe <= {op_en_pipe[OP_EN_DELAY-2:0], op_en_cur};
    end
  end

  assign reg2dp_op_en = op_en_pipe[OP_EN_DELAY-1];

  // field mux by consumer
  assign reg2dp_width             = consumer ? d1_width : d0_width;
  assign reg2dp_height            = consumer ? d1_height : d0_height;
  assign reg2dp_channel           = consumer ? d1_channel : d0_channel;
  assign reg2dp_src_base_addr_low = consumer ? d1_src_base_addr_low : d0_src_base_addr_low;
  assign reg2dp_src_line_stride   = consumer ? d1_src_line_stride : d0_src_line_stride;

  a_done_known: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !$isunknown(dp2reg_done))
    else $error("dp2reg_done is X");

endmodule

// File: design/ptr_status_group.sv
/* general register group: producer pointer register,
   read-only pointer and status words */
module ptr_status_group import rdma_reg_pkg::*; (
  input  logic        autosa_core_clk,
  input  logic        autosa_core_rstn,
  input  logic        wr_en,
  input  reg_offset_t reg_offset,
  input  reg_data_t   reg_wr_data,
  input  logic        consumer,
  input  logic        d0_op_en,
  input  logic        d1_op_en,
  output logic        producer,
  output reg_data_t   rd_data
);

  grp_status_e status_0;
  grp_status_e status_1;

  // producer is the only writable bit here
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      producer <= 1'b0;
    end else if (wr_en && (reg_offset == PTR_OFFS)) begin
      producer <= reg_wr_data[0];
    end
  end

  // enabled group waits while datapath works on the other one
  assign status_0 = !d0_op_en ? IDLE : (consumer ? PENDING : RUNNING);
  assign status_1 = !d1_op_en ? IDLE : (!consumer ? PENDING : RUNNING);

  always_comb begin
    rd_data = '0;
    case (reg_offset)
      PTR_OFFS: begin
        rd_data[0]                = producer;
        rd_data[PTR_CONSUMER_BIT] = consumer;  // read only
      end
      STATUS_OFFS: begin
        rd_data[1:0]               = status_0;
        rd_data[STATUS_1_LSB +: 2] = status_1;
      end
      default: ;  // unmapped reads 0
    endcase
  end

endmodule

// File: design/rdma_reg_pkg.sv
/* rdma register block shared definitions: widths, packet and register types,
   group status enum, csb packet fields, register offsets and layout */
package rdma_reg_pkg;

  //////////////////////////////////////////////////
  // widths
  localparam int CSB_REQ_W    = 63;
  localparam int CSB_RESP_W   = 34;
  localparam int CSB_ADDR_W   = 22;  // word address
  localparam int REG_OFFSET_W = 12;  // 4 KB byte space
  localparam int REG_DATA_W   = 32;
  localparam int CUBE_DIM_W   = 13;

  typedef logic [CSB_REQ_W-1:0]    csb_req_pd_t;
  typedef logic [CSB_RESP_W-1:0]   csb_resp_pd_t;
  typedef logic [CSB_ADDR_W-1:0]   csb_addr_t;
  typedef logic [REG_OFFSET_W-1:0] reg_offset_t;
  typedef logic [REG_DATA_W-1:0]   reg_data_t;
  typedef logic [CUBE_DIM_W-1:0]   cube_dim_t;

  // per-group status seen by software
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    RUNNING = 2'd1,
    PENDING = 2'd2
  } grp_status_e;

  //////////////////////////////////////////////////
  // csb packet fields
  localparam int REQ_WDAT_LSB    = 22;  // wdat in 53..22
  localparam int REQ_WRITE_BIT   = 54;
  localparam int REQ_NPOSTED_BIT = 55;  // 62..56 not used

  localparam logic RESP_TYPE_RD = 1'b0;
  localparam logic RESP_TYPE_WR = 1'b1;

  //////////////////////////////////////////////////
  // register map
  localparam reg_offset_t PTR_OFFS          = 12'h000;
  localparam reg_offset_t STATUS_OFFS       = 12'h004;
  localparam reg_offset_t OP_ENABLE_OFFS    = 12'h008;
  localparam reg_offset_t WIDTH_OFFS        = 12'h00C;
  localparam reg_offset_t HEIGHT_OFFS       = 12'h010;
  localparam reg_offset_t CHANNEL_OFFS      = 12'h014;
  localparam reg_offset_t SRC_BASE_LOW_OFFS = 12'h018;
  localparam reg_offset_t LINE_STRIDE_OFFS  = 12'h01C;
  localparam reg_offset_t DUAL_BASE_OFFS    = 12'h008;  // first ping-pong offset

  localparam int PTR_CONSUMER_BIT = 16;  // producer sits in bit 0
  localparam int STATUS_1_LSB     = 16;  // status_0 sits in 1..0

  localparam int OP_EN_DELAY = 3;  // op_en to datapath latency

endpackage

// File: design/rdma_reg_top.sv
/* rdma register block top: csb decode, routing, general group,
   two ping-pong config groups, ping-pong control, response stage */
module rdma_reg_top import rdma_reg_pkg::*; (
  input  logic         autosa_core_clk,
  input  logic         autosa_core_rstn,
  input  logic         csb2cdp_rdma_req_pvld,
  input  csb_req_pd_t  csb2cdp_rdma_req_pd,
  output logic         csb2cdp_rdma_req_prdy,
  output logic         cdp_rdma2csb_resp_valid,
  output csb_resp_pd_t cdp_rdma2csb_resp_pd,
  input  logic         dp2reg_done,
  output logic         reg2dp_op_en,
  output cube_dim_t    reg2dp_width,
  output cube_dim_t    reg2dp_height,
  output cube_dim_t    reg2dp_channel,
  output reg_data_t    reg2dp_src_base_addr_low,
  output reg_data_t    reg2dp_src_line_stride
);

  //////////////////////////////////////////////////
  // internal wires
  logic        reg_wr_en;
  logic        reg_rd_en;
  logic        reg_nposted;
  reg_offset_t reg_offset;
  reg_data_t   reg_wr_data;
  reg_data_t   reg_rd_data;
  logic        s_wr_en;
  logic        d0_wr_en;
  logic        d1_wr_en;
  reg_data_t   s_rd_data;
  reg_data_t   d0_rd_data;
  reg_data_t   d1_rd_data;
  logic        producer;
  logic        consumer;
  logic        d0_op_en;
  logic        d1_op_en;
  logic        d0_op_en_set;
  logic        d1_op_en_set;
  cube_dim_t   d0_width, d0_height, d0_channel;
  cube_dim_t   d1_width, d1_height, d1_channel;
  reg_data_t   d0_src_base_addr_low, d0_src_line_stride;
  reg_data_t   d1_src_base_addr_low, d1_src_line_stride;

  // request decode
  csb_req_decode u_csb_req_decode (
    .autosa_core_clk, .autosa_core_rstn,
    .csb2cdp_rdma_req_pvld, .csb2cdp_rdma_req_pd, .csb2cdp_rdma_req_prdy,
    .reg_wr_en, .reg_rd_en, .reg_nposted, .reg_offset, .reg_wr_data
  );

  // group select and write gating
  reg_access_route u_reg_access_route (
    .autosa_core_clk, .autosa_core_rstn,
    .reg_wr_en, .reg_offset, .producer, .d0_op_en, .d1_op_en,
    .s_rd_data, .d0_rd_data, .d1_rd_data,
    .s_wr_en, .d0_wr_en, .d1_wr_en, .reg_rd_data
  );

  ptr_status_group u_ptr_status_group (
    .autosa_core_clk, .autosa_core_rstn,
    .wr_en (s_wr_en), .reg_offset, .reg_wr_data,
    .consumer, .d0_op_en, .d1_op_en,
    .producer, .rd_data (s_rd_data)
  );

  //////////////////////////////////////////////////
  // ping-pong copies
  layer_cfg_group u_layer_cfg_d0 (
    .autosa_core_clk, .autosa_core_rstn,
    .wr_en (d0_wr_en), .reg_offset, .reg_wr_data,
    .op_en (d0_op_en), .op_en_set (d0_op_en_set),
    .width (d0_width), .height (d0_height), .channel (d0_channel),
    .src_base_addr_low (d0_src_base_addr_low), .src_line_stride (d0_src_line_stride),
    .rd_data (d0_rd_data)
  );

  layer_cfg_group u_layer_cfg_d1 (
    .autosa_core_clk, .autosa_core_rstn,
    .wr_en (d1_wr_en), .reg_offset, .reg_wr_data,
    .op_en (d1_op_en), .op_en_set (d1_op_en_set),
    .width (d1_width), .height (d1_height), .channel (d1_channel),
    .src_base_addr_low (d1_src_base_addr_low), .src_line_stride (d1_src_line_stride),
    .rd_data (d1_rd_data)
  );

  pingpong_ctrl u_pingpong_ctrl (
    .autosa_core_clk, .autosa_core_rstn,
    .dp2reg_done, .d0_op_en_set, .d1_op_en_set,
    .d0_width, .d0_height, .d0_channel, .d0_src_base_addr_low, .d0_src_line_stride,
    .d1_width, .d1_height, .d1_channel, .d1_src_base_addr_low, .d1_src_line_stride,
    .consumer, .d0_op_en, .d1_op_en, .reg2dp_op_en,
    .reg2dp_width, .reg2dp_height, .reg2dp_channel,
    .reg2dp_src_base_addr_low, .reg2dp_src_line_stride
  );

  // response
  csb_resp_pack u_csb_resp_pack (
    .autosa_core_clk, .autosa_core_rstn,
    .reg_rd_en, .reg_wr_en, .reg_nposted, .reg_rd_data,
    .cdp_rdma2csb_resp_valid, .cdp_rdma2csb_resp_pd
  );

endmodule

// File: design/reg_access_route.sv
/* register access routing: general vs ping-pong range decode,
   write gating by op_en and read data merge */
module reg_access_route import rdma_reg_pkg::*; (
  input  logic        autosa_core_clk,
  input  logic        autosa_core_rstn,
  input  logic        reg_wr_en,
  input  reg_offset_t reg_offset,
  input  logic        producer,
  input  logic        d0_op_en,
  input  logic        d1_op_en,
  input  reg_data_t   s_rd_data,
  input  reg_data_t   d0_rd_data,
  input  reg_data_t   d1_rd_data,
  output logic        s_wr_en,
  output logic        d0_wr_en,
  output logic        d1_wr_en,
  output reg_data_t   reg_rd_data
);

  logic sel_s;
  logic sel_d0;
  logic sel_d1;

  // general group below the dual base, else the producer's copy
  assign sel_s  = (reg_offset < DUAL_BASE_OFFS);
  assign sel_d0 = ~sel_s & ~producer;
  assign sel_d1 = ~sel_s & producer;

  assign s_wr_en  = reg_wr_en & sel_s;
  assign d0_wr_en = reg_wr_en & sel_d0 & ~d0_op_en;  // locked while enabled
  assign d1_wr_en = reg_wr_en & sel_d1 & ~d1_op_en;

  // one-hot select, unmapped reads give 0 from the groups
  assign reg_rd_data = ({REG_DATA_W{sel_s}} & s_rd_data)
                     | ({REG_DATA_W{sel_d0}} & d0_rd_data)
                     | ({REG_DATA_W{sel_d1}} & d1_rd_data);

  // software must not touch a copy the datapath owns
  a_no_wr_d0_busy: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !(reg_wr_en && sel_d0 && d0_op_en))
    else $error("write to group 0 while its op_en is set");

  a_no_wr_d1_busy: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !(reg_wr_en && sel_d1 && d1_op_en))
    else $error("write to group 1 while its op_en is set");

endmodule

// File: sources.f
+incdir+verification
design/rdma_reg_pkg.sv
design/csb_req_decode.sv
design/reg_access_route.sv
design/ptr_status_group.sv
design/layer_cfg_group.sv
design/pingpong_ctrl.sv
design/csb_resp_pack.sv
design/rdma_reg_top.sv
verification/rdma_reg_tb.sv

// File: verification/rdma_reg_tests.svh
/* directed tests for the rdma register block, plus register word
   builders and config write and readback helpers */
`ifndef RDMA_REG_TESTS_SVH
`define RDMA_REG_TESTS_SVH

function automatic reg_data_t ptr_word(input logic producer, input logic consumer);
  reg_data_t w;
  w     = '0;
  w[0]  = producer;
  w[16] = consumer;
  return w;
endfunction

function automatic reg_data_t status_word(input grp_status_e s0, input grp_status_e s1);
  reg_data_t w;
  w        = '0;
  w[1:0]   = s0;
  w[17:16] = s1;
  return w;
endfunction

task automatic read_expect(input reg_offset_t offs, input reg_data_t exp, input string name);
  reg_data_t rd;
  csb_read(offs, rd);
  check_data(name, rd, exp);
endtask

// random config into the producer's copy, model keeps 13 bit dims
task automatic write_cfg(input int g);
  reg_data_t w;
  reg_data_t h;
  reg_data_t c;
  w = next_random();
  h = next_random();
  c = next_random();
  exp_width[g]   = w[12:0];
  exp_height[g]  = h[12:0];
  exp_channel[g] = c[12:0];
  exp_base[g]    = next_random();
  exp_stride[g]  = next_random();
  csb_write(WIDTH_OFFS, w, 1'b0);
  csb_write(HEIGHT_OFFS, h, 1'b1);
  csb_write(CHANNEL_OFFS, c, 1'b0);
  csb_write(SRC_BASE_LOW_OFFS, exp_base[g], 1'b1);
  csb_write(LINE_STRIDE_OFFS, exp_stride[g], 1'b0);
endtask

task automatic read_cfg(input int g);
  read_expect(WIDTH_OFFS, reg_data_t'(exp_width[g]), "width");
  read_expect(HEIGHT_OFFS, reg_data_t'(exp_height[g]), "height");
  read_expect(CHANNEL_OFFS, reg_data_t'(exp_channel[g]), "channel");
  read_expect(SRC_BASE_LOW_OFFS, exp_base[g], "src_base_addr_low");
  read_expect(LINE_STRIDE_OFFS, exp_stride[g], "src_line_stride");
endtask

task automatic check_dp_fields(input int g);
  check_dim("reg2dp_width", reg2dp_width, exp_width[g]);
  check_dim("reg2dp_height", reg2dp_height, exp_height[g]);
  check_dim("reg2dp_channel", reg2dp_channel, exp_channel[g]);
  check_data("reg2dp_src_base_addr_low", reg2dp_src_base_addr_low, exp_base[g]);
  check_data("reg2dp_src_line_stride", reg2dp_src_line_stride, exp_stride[g]);
endtask

// low for the pipe depth, high on the next falling edge
task automatic expect_op_en_rise();
  repeat (3) begin
    check_bit("reg2dp_op_en", reg2dp_op_en, 1'b0);
    @(negedge autosa_core_clk);
  end
  check_bit("reg2dp_op_en", reg2dp_op_en, 1'b1);
endtask

//////////////////////////////////////////////////
// directed tests
task automatic test_reset_and_resp();
  check_bit("csb2cdp_rdma_req_prdy", csb2cdp_rdma_req_prdy, 1'b1);
  check_bit("reg2dp_op_en", reg2dp_op_en, 1'b0);
  read_expect(PTR_OFFS, '0, "ptr word");
  read_expect(STATUS_OFFS, '0, "status word");
  read_expect(OP_ENABLE_OFFS, '0, "op_enable");
  exp_width[0]   = '0;
  exp_height[0]  = '0;
  exp_channel[0] = '0;
  exp_base[0]    = '0;
  exp_stride[0]  = '0;
  read_cfg(0);
  csb_write(12'h020, 32'hdead_beef, 1'b0);  // unmapped, posted
  csb_write(12'h024, 32'h1234_5678, 1'b1);  // unmapped, non-posted
  read_expect(12'h020, '0, "unmapped word");
endtask

task automatic test_cfg_readback();
  write_cfg(0);
  read_cfg(0);
  csb_write(PTR_OFFS, 32'h1, 1'b1);  // producer to copy 1
  write_cfg(1);
  read_cfg(1);
  read_expect(PTR_OFFS, ptr_word(1'b1, 1'b0), "ptr word");
endtask

task automatic test_enable_group0();
  csb_write(PTR_OFFS, 32'h0, 1'b0);
  csb_write(OP_ENABLE_OFFS, 32'h1, 1'b0);
  expect_op_en_rise();
  check_dp_fields(0);
  read_expect(STATUS_OFFS, status_word(RUNNING, IDLE), "status word");
  read_expect(OP_ENABLE_OFFS, 32'h1, "op_enable");
endtask

task automatic test_pingpong_switch();
  csb_write(PTR_OFFS, 32'h1, 1'b0);
  csb_write(OP_ENABLE_OFFS, 32'h1, 1'b1);  // queue copy 1 behind copy 0
  read_expect(STATUS_OFFS, status_word(RUNNING, PENDING), "status word");
  check_bit("reg2dp_op_en", reg2dp_op_en, 1'b1);
  pulse_done();
  expect_op_en_rise();
  check_dp_fields(1);
  read_expect(PTR_OFFS, ptr_word(1'b1, 1'b1), "ptr word");
  read_expect(STATUS_OFFS, status_word(IDLE, RUNNING), "status word");
endtask

task automatic test_back_to_idle();
  pulse_done();
  repeat (6) begin
    check_bit("reg2dp_op_en", reg2dp_op_en, 1'b0);  // nothing left to run
    @(negedge autosa_core_clk);
  end
  read_expect(PTR_OFFS, ptr_word(1'b1, 1'b0), "ptr word");
  read_expect(STATUS_OFFS, status_word(IDLE, IDLE), "status word");
  csb_write(PTR_OFFS, 32'h0, 1'b1);
  write_cfg(0);
  read_cfg(0);
  check_dp_fields(0);
  check_bit("reg2dp_op_en", reg2dp_op_en, 1'b0);
endtask

`endif

// File: verification/rdma_reg_tb.sv
/* testbench for the rdma register block: clock, reset, DUT, timeout,
   csb driver tasks, compare tasks and the directed test sequence */
module rdma_reg_tb import rdma_reg_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES   = 3;
  localparam int CSB_OPS        = 60;  // reads and writes over all tests
  localparam int CSB_OP_CYCLES  = 3;   // drive, sample, response
  localparam int WAIT_CYCLES    = 40;  // done pulses and op_en latency checks
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + CSB_OPS * CSB_OP_CYCLES + WAIT_CYCLES);

  logic         autosa_core_clk = 1'b0;
  logic         autosa_core_rstn;
  logic         csb2cdp_rdma_req_pvld;
  csb_req_pd_t  csb2cdp_rdma_req_pd;
  logic         csb2cdp_rdma_req_prdy;
  logic         cdp_rdma2csb_resp_valid;
  csb_resp_pd_t cdp_rdma2csb_resp_pd;
  logic         dp2reg_done;
  logic         reg2dp_op_en;
  cube_dim_t    reg2dp_width;
  cube_dim_t    reg2dp_height;
  cube_dim_t    reg2dp_channel;
  reg_data_t    reg2dp_src_base_addr_low;
  reg_data_t    reg2dp_src_line_stride;

  int          cycle_count = 0;
  logic [31:0] rng_state = 32'h467440e0;

  // expected contents of both ping-pong copies
  cube_dim_t exp_width [2];
  cube_dim_t exp_height [2];
  cube_dim_t exp_channel [2];
  reg_data_t exp_base [2];
  reg_data_t exp_stride [2];

  rdma_reg_top i_rdma_reg_top (.*);

  always #4 autosa_core_clk = ~autosa_core_clk;  // 8 ns period

  //////////////////////////////////////////////////
  // failure handling and compares
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  always @(posedge autosa_core_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_error("timeout: the test sequence did not finish in time");
    end
  end

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_dim(input string name, input cube_dim_t got, input cube_dim_t exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input csb_resp_pd_t got, input csb_resp_pd_t exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // xorshift32 random source
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  //////////////////////////////////////////////////
  // csb driver
  function automatic csb_req_pd_t make_req_pd(input reg_offset_t offs, input reg_data_t data,
                                              input logic write, input logic nposted);
    csb_req_pd_t pd;
    pd        = '0;
    pd[21:0]  = csb_addr_t'(offs >> 2);  // byte offset to word address
    pd[53:22] = data;
    pd[54]    = write;
    pd[55]    = nposted;
    return pd;
  endfunction

  // one request strobe, then wait for the edge that samples it
  task automatic send_req(input csb_req_pd_t pd);
    @(negedge autosa_core_clk);
    check_bit("cdp_rdma2csb_resp_valid", cdp_rdma2csb_resp_valid, 1'b0);  // no stray resp
    csb2cdp_rdma_req_pvld = 1'b1;
    csb2cdp_rdma_req_pd   = pd;
    @(negedge autosa_core_clk);
    check_bit("cdp_rdma2csb_resp_valid", cdp_rdma2csb_resp_valid, 1'b0);  // not yet
    csb2cdp_rdma_req_pvld = 1'b0;
    csb2cdp_rdma_req_pd   = '0;
    @(negedge autosa_core_clk);  // one cycle after sampling edge
  endtask

  task automatic csb_write(input reg_offset_t offs, input reg_data_t data, input logic nposted);
    send_req(make_req_pd(offs, data, 1'b1, nposted));
    if (nposted) begin
      if (cdp_rdma2csb_resp_valid !== 1'b1)
        stop_on_error("no response arrived for a non-posted write");
      check_resp("cdp_rdma2csb_resp_pd", cdp_rdma2csb_resp_pd, {1'b1, 1'b0, 32'h0});
    end else begin
      check_bit("cdp_rdma2csb_resp_valid", cdp_rdma2csb_resp_valid, 1'b0);
    end
  endtask

  task automatic csb_read(input reg_offset_t offs, output reg_data_t data);
    send_req(make_req_pd(offs, '0, 1'b0, 1'b0));
    if (cdp_rdma2csb_resp_valid !== 1'b1)
      stop_on_error("no response arrived for a read");
    check_bit("cdp_rdma2csb_resp_pd[33]", cdp_rdma2csb_resp_pd[33], 1'b0);
    check_bit("cdp_rdma2csb_resp_pd[32]", cdp_rdma2csb_resp_pd[32], 1'b0);
    data = cdp_rdma2csb_resp_pd[31:0];
  endtask

  task automatic pulse_done();
    @(negedge autosa_core_clk);
    dp2reg_done = 1'b1;
    @(negedge autosa_core_clk);
    dp2reg_done = 1'b0;
  endtask

  `include "rdma_reg_tests.svh"

  initial begin
    autosa_core_rstn      = 1'b0;
    csb2cdp_rdma_req_pvld = 1'b0;
    csb2cdp_rdma_req_pd   = '0;
    dp2reg_done           = 1'b0;
    repeat (RESET_CYCLES) @(negedge autosa_core_clk);
    autosa_core_rstn = 1'b1;
    test_reset_and_resp();
    test_cfg_readback();
    test_enable_group0();
    test_pingpong_switch();
    test_back_to_idle();
    $display("TB PASSED");
    $finish;
  end

endmodule
